//--- bench/alu_checker.sv
module alu_checker #(
    parameter int latency = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  alu_pkg::opcode_t op,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    input  logic             out_valid,
    input  alu_pkg::word_t   result,
    output int               value_errors,
    output int               protocol_errors,
    output int               pending
);
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    // expected result and issue cycle of every operation in flight
    word_t       exp_q  [$];
    int unsigned when_q [$];

    int unsigned cycle       = 0;
    int unsigned reset_edges = 0;
    int          value_errs  = 0;
    int          proto_errs  = 0;
    int          pending_n   = 0;

    assign value_errors    = value_errs;
    assign protocol_errors = proto_errs;
    assign pending         = pending_n;

    // RV64I integer result straight from the instruction fields
    function automatic word_t expected_result(
        input opcode_t    opc,
        input logic [2:0] f3,
        input logic [6:0] f7,
        input word_t      x,
        input word_t      y
    );
        logic               legal;
        logic               alt;
        logic               is_w;
        logic [31:0]        low;
        logic signed [63:0] xs;
        logic signed [31:0] xls;
        word_t              r;
        legal = 1'b0;
        alt   = 1'b0;
        is_w  = 1'b0;
        low   = '0;
        r     = '0;
        xs    = x;
        xls   = x[31:0];
        case (opc)
            op_lui: begin
                return y;
            end
            op_op_imm: begin
                // slti and sltiu are rejected
                legal = (f3 != 3'b010) && (f3 != 3'b011);
                if (f3 == f3_srx) begin
                    // funct7[0] is shamt bit 5 here
                    legal = (f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000);
                    alt   = f7[5];
                end
            end
            op_op: begin
                legal = (f7 == 7'b0000000 && f3 != 3'b010 && f3 != 3'b011) ||
                        (f7 == 7'b0100000 && (f3 == f3_add_sub || f3 == f3_srx));
                alt   = f7[5];
            end
            op_imm_32: begin
                is_w  = 1'b1;
                legal = (f3 == f3_add_sub) || (f3 == f3_sll) ||
                        (f3 == f3_srx && (f7 == 7'b0000000 || f7 == 7'b0100000));
                alt   = (f3 == f3_srx) && f7[5];
            end
            op_op_32: begin
                is_w  = 1'b1;
                legal = (f7 == 7'b0000000 &&
                         (f3 == f3_add_sub || f3 == f3_sll || f3 == f3_srx)) ||
                        (f7 == 7'b0100000 && (f3 == f3_add_sub || f3 == f3_srx));
                alt   = f7[5];
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            return illegal_result;
        end
        if (is_w) begin
            // 32-bit op, then sign-extend from bit 31
            case (f3)
                f3_add_sub: low = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
                f3_sll:     low = x[31:0] << y[4:0];
                default: begin
                    if (alt) begin
                        low = xls >>> y[4:0];
                    end else begin
                        low = x[31:0] >> y[4:0];
                    end
                end
            endcase
            r = {{32{low[31]}}, low};
        end else begin
            case (f3)
                f3_add_sub: r = alt ? x - y : x + y;
                f3_sll:     r = x << y[5:0];
                f3_xor:     r = x ^ y;
                f3_or:      r = x | y;
                f3_and:     r = x & y;
                default: begin
                    if (alt) begin
                        r = xs >>> y[5:0];
                    end else begin
                        r = x >> y[5:0];
                    end
                end
            endcase
        end
        return r;
    endfunction

    always @(posedge clk) begin
        word_t       want;
        int unsigned issued;
        cycle = cycle + 1;
        if (!rst_n) begin
            // outputs are cleared from the first reset edge on
            if (reset_edges > 0 && (out_valid !== 1'b0 || result !== '0)) begin
                $display("out_valid or result not cleared during reset at %0t", $realtime);
                proto_errs = proto_errs + 1;
            end
            reset_edges = reset_edges + 1;
        end else begin
            if (in_valid) begin
                exp_q.push_back(expected_result(op, funct3, funct7, a, b));
                when_q.push_back(cycle);
            end
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid high at %0t with no operation in flight", $realtime);
                    proto_errs = proto_errs + 1;
                end else begin
                    want   = exp_q.pop_front();
                    issued = when_q.pop_front();
                    // result must show up exactly latency edges after issue
                    if (cycle != issued + latency) begin
                        $display("result at %0t came %0d cycles after issue, not %0d",
                                 $realtime, cycle - issued, latency);
                        proto_errs = proto_errs + 1;
                    end
                    if (result !== want) begin
                        $display("error at %0t: result expected %h actual %h",
                                 $realtime, want, result);
                        value_errs = value_errs + 1;
                    end
                end
            end else if (out_valid !== 1'b0) begin
                $display("out_valid is unknown at %0t", $realtime);
                proto_errs = proto_errs + 1;
            end
        end
        pending_n = exp_q.size();
    end

endmodule

//--- bench/tb_alu.sv
module tb_alu;
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    localparam int stages     = 2;
    localparam int n_directed = 40;
    localparam int n_random   = 400;
    // at most one idle cycle per operation, plus reset and pipeline fill
    localparam int max_cycles = 2 * (n_directed + n_random + 10 + stages + 2) + 100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    opcode_t    op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      a;
    word_t      b;
    logic       out_valid;
    word_t      result;

    int     value_errors;
    int     protocol_errors;
    int     pending;
    integer seed   = 32'h1b3e4aa3;
    int     cycles = 0;

    // 40 ns clock
    always #20 clk = ~clk;

    alu_pipe_top #(
        .STAGES (stages)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .funct3    (funct3),
        .funct7    (funct7),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    alu_checker #(
        .latency (stages + 2)
    ) chk0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .op              (op),
        .funct3          (funct3),
        .funct7          (funct7),
        .a               (a),
        .b               (b),
        .out_valid       (out_valid),
        .result          (result),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    task automatic report_counts(input int lost);
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors + lost);
    endtask

    // stops a stalled pipeline from hanging the run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            report_counts(pending);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic word_t draw_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // one operation, driven just after the rising edge
    task automatic issue_op(
        input opcode_t    o,
        input logic [2:0] f3,
        input logic [6:0] f7,
        input word_t      x,
        input word_t      y
    );
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        op       = o;
        funct3   = f3;
        funct7   = f7;
        a        = x;
        b        = y;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // mostly legal opcodes, some unknown ones
    task automatic random_op();
        logic [31:0] r;
        opcode_t     o;
        logic [6:0]  f7;
        r = $random(seed);
        case (r[2:0])
            3'd0:       o = op_lui;
            3'd1, 3'd2: o = op_op;
            3'd3:       o = op_op_imm;
            3'd4:       o = op_imm_32;
            3'd5, 3'd6: o = op_op_32;
            default:    o = r[15:9];
        endcase
        // M encodings and shamt bit 5 come from the third case
        case (r[5:4])
            2'd0:    f7 = 7'b0000000;
            2'd1:    f7 = 7'b0100000;
            2'd2:    f7 = {6'b000000, r[6]};
            default: f7 = r[22:16];
        endcase
        issue_op(o, r[25:23], f7, draw_word(), draw_word());
    endtask

    initial begin
        logic [31:0] gap;
        int          lost;
        in_valid = 1'b0;
        op       = '0;
        funct3   = '0;
        funct7   = '0;
        a        = '0;
        b        = '0;
        rst_n    = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // OP, back to back; shifts see random upper bits of b
        issue_op(op_op, f3_add_sub, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op, f3_add_sub, 7'b0100000, draw_word(), draw_word());
        issue_op(op_op, f3_sll, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op, f3_srx, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op, f3_srx, 7'b0100000, draw_word() | 64'h8000_0000_0000_0000,
                 draw_word());
        issue_op(op_op, f3_xor, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op, f3_or, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op, f3_and, 7'b0000000, draw_word(), draw_word());

        // OP_IMM, funct7 ignored except for srli/srai
        issue_op(op_op_imm, f3_add_sub, 7'b1010101, draw_word(), draw_word());
        issue_op(op_op_imm, f3_xor, 7'b0100000, draw_word(), draw_word());
        issue_op(op_op_imm, f3_or, 7'b1111111, draw_word(), draw_word());
        issue_op(op_op_imm, f3_and, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op_imm, f3_sll, 7'b0100001, draw_word(), draw_word());
        issue_op(op_op_imm, f3_srx, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op_imm, f3_srx, 7'b0000001, 64'hf000_0000_0000_0001, 64'd33);
        issue_op(op_op_imm, f3_srx, 7'b0100000, 64'h8765_4321_0000_0000, 64'd12);
        issue_op(op_op_imm, f3_srx, 7'b0100001, 64'hc000_0000_0000_00ff, 64'd40);

        // W forms, bit 31 of the result both clear and set
        issue_op(op_imm_32, f3_add_sub, 7'b1100110, 64'h0000_0000_7fff_fff0, 64'h20);
        issue_op(op_imm_32, f3_add_sub, 7'b0000000, 64'hdead_beef_0000_0005, 64'd3);
        issue_op(op_op_32, f3_add_sub, 7'b0000000, 64'h1234_5678_7000_0000,
                 64'h1000_0000);
        issue_op(op_op_32, f3_add_sub, 7'b0000000, 64'hffff_ffff_0000_0001, 64'd1);
        issue_op(op_op_32, f3_add_sub, 7'b0100000, 64'd0, 64'd1);
        issue_op(op_op_32, f3_add_sub, 7'b0100000, 64'h8000_0000_0000_0005, 64'd3);
        issue_op(op_imm_32, f3_sll, 7'b0100000, 64'd1, 64'd31);
        issue_op(op_op_32, f3_sll, 7'b0000000, 64'd3, 64'hffff_ffff_ffff_ffe4);
        issue_op(op_imm_32, f3_srx, 7'b0000000, 64'h0000_0000_8000_0000, 64'h24);
        issue_op(op_op_32, f3_srx, 7'b0000000, 64'h5555_5555_8000_0000, 64'd0);
        issue_op(op_imm_32, f3_srx, 7'b0100000, 64'h0000_0000_8000_0000, 64'd4);
        issue_op(op_op_32, f3_srx, 7'b0100000, 64'h1234_5678_4000_0000, 64'h21);

        // LUI passes b whatever a holds
        issue_op(op_lui, 3'b000, 7'b0000000, draw_word(), 64'hffff_ffff_8765_4000);

        // rejected encodings
        issue_op(op_op, f3_add_sub, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op, f3_srx, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op_32, f3_add_sub, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op_32, f3_and, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op, f3_xor, 7'b0100000, draw_word(), draw_word());
        issue_op(op_op_32, f3_sll, 7'b0100000, draw_word(), draw_word());
        issue_op(op_imm_32, f3_srx, 7'b0000001, draw_word(), draw_word());
        issue_op(op_op_imm, 3'b010, 7'b0000000, draw_word(), draw_word());
        issue_op(op_op_imm, 3'b011, 7'b0000000, draw_word(), draw_word());
        issue_op(7'b1100011, f3_add_sub, 7'b0000000, draw_word(), draw_word());

        // random mix with occasional idle cycles
        for (int i = 0; i < n_random; i++) begin
            gap = $random(seed);
            if (gap[1:0] == 2'b00) begin
                idle_cycle();
            end
            random_op();
        end
        idle_cycle();

        // let the pipeline drain, then watch for stray out_valid
        for (int i = 0; i < 20 && pending != 0; i++) begin
            @(posedge clk);
        end
        repeat (stages + 2) @(posedge clk);

        lost = pending;
        if (lost != 0) begin
            $display("%0d operations never produced a result", lost);
        end
        report_counts(lost);
        if (value_errors + protocol_errors + lost == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/alu_pkg.sv
rtl/alu_decode.sv
rtl/alu_operand_pipe.sv
rtl/alu_execute.sv
rtl/alu_pipe_top.sv
bench/alu_checker.sv
bench/tb_alu.sv

//--- rtl/alu_decode.sv
module alu_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  alu_pkg::opcode_t  op,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    input  alu_pkg::word_t    a,
    input  alu_pkg::word_t    b,
    output logic              dec_valid,
    output alu_pkg::alu_cmd_e dec_cmd,
    output logic              dec_word,
    output alu_pkg::word_t    dec_a,
    output alu_pkg::word_t    dec_b
);
    import alu_pkg::*;

    alu_cmd_e cmd_nxt;
    logic     word_nxt;

    // opcode/funct3/funct7 to command
    // anything not matched below stays illegal
    always_comb begin
        cmd_nxt  = cmd_illegal;
        word_nxt = 1'b0;
        case (op)
            op_lui: begin
                cmd_nxt = cmd_pass_b;
            end
            op_op_imm: begin
                // funct7 only matters for the right shifts
                case (funct3)
                    f3_add_sub: cmd_nxt = cmd_add;
                    f3_sll:     cmd_nxt = cmd_sll;
                    f3_xor:     cmd_nxt = cmd_xor;
                    f3_or:      cmd_nxt = cmd_or;
                    f3_and:     cmd_nxt = cmd_and;
                    f3_srx: begin
                        // bit 0 of funct7 belongs to shamt[5]
                        if (funct7[6:1] == 6'b000000) begin
                            cmd_nxt = cmd_srl;
                        end else if (funct7[6:1] == 6'b010000) begin
                            cmd_nxt = cmd_sra;
                        end
                    end
                    default: cmd_nxt = cmd_illegal;
                endcase
            end
            op_op: begin
                // M encodings (funct7 = 0000001) fall through as illegal
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        f3_add_sub: cmd_nxt = cmd_add;
                        f3_sll:     cmd_nxt = cmd_sll;
                        f3_xor:     cmd_nxt = cmd_xor;
                        f3_srx:     cmd_nxt = cmd_srl;
                        f3_or:      cmd_nxt = cmd_or;
                        f3_and:     cmd_nxt = cmd_and;
                        default:    cmd_nxt = cmd_illegal;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == f3_add_sub) begin
                        cmd_nxt = cmd_sub;
                    end else if (funct3 == f3_srx) begin
                        cmd_nxt = cmd_sra;
                    end
                end
            end
            op_imm_32: begin
                word_nxt = 1'b1;
                case (funct3)
                    f3_add_sub: cmd_nxt = cmd_add;
                    f3_sll:     cmd_nxt = cmd_sll;
                    f3_srx: begin
                        if (funct7 == 7'b0000000) begin
                            cmd_nxt = cmd_srl;
                        end else if (funct7 == 7'b0100000) begin
                            cmd_nxt = cmd_sra;
                        end
                    end
                    default: cmd_nxt = cmd_illegal;
                endcase
            end
            op_op_32: begin
                word_nxt = 1'b1;
                // addw/sllw/srlw with funct7 zero, subw/sraw with bit 5 set
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        f3_add_sub: cmd_nxt = cmd_add;
                        f3_sll:     cmd_nxt = cmd_sll;
                        f3_srx:     cmd_nxt = cmd_srl;
                        default:    cmd_nxt = cmd_illegal;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == f3_add_sub) begin
                        cmd_nxt = cmd_sub;
                    end else if (funct3 == f3_srx) begin
                        cmd_nxt = cmd_sra;
                    end
                end
            end
            default: cmd_nxt = cmd_illegal;
        endcase
    end

    // valid strobe, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // payload only captured with a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_cmd  <= cmd_nxt;
            dec_word <= word_nxt;
            dec_a    <= a;
            dec_b    <= b;
        end
    end

endmodule

//--- rtl/alu_execute.sv
module alu_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  alu_pkg::alu_cmd_e ex_cmd,
    input  logic              ex_word,
    input  alu_pkg::word_t    ex_a,
    input  alu_pkg::word_t    ex_b,
    output logic              out_valid,
    output alu_pkg::word_t    result
);
    import alu_pkg::*;

    // shift amounts, 6 bits for doubleword and 5 for word ops
    logic [5:0]         shamt_d;
    logic [4:0]         shamt_w;

    // signed views for arithmetic right shift
    logic signed [63:0] a_s;
    logic signed [31:0] a_lo_s;

    word_t              res_d;
    logic [31:0]        res_w;
    alu_word_u          res_u;

    assign shamt_d = ex_b[5:0];
    assign shamt_w = ex_b[4:0];
    assign a_s     = ex_a;
    assign a_lo_s  = ex_a[31:0];

    // full-width result
    always_comb begin
        case (ex_cmd)
            cmd_add:    res_d = ex_a + ex_b;
            cmd_sub:    res_d = ex_a - ex_b;
            cmd_sll:    res_d = ex_a << shamt_d;
            cmd_srl:    res_d = ex_a >> shamt_d;
            cmd_sra:    res_d = a_s >>> shamt_d;
            cmd_xor:    res_d = ex_a ^ ex_b;
            cmd_or:     res_d = ex_a | ex_b;
            cmd_and:    res_d = ex_a & ex_b;
            cmd_pass_b: res_d = ex_b;
            default:    res_d = illegal_result;
        endcase
    end

    // low-word result for the W forms
    // only add/sub and the shifts exist as W ops
    always_comb begin
        case (ex_cmd)
            cmd_add: res_w = ex_a[31:0] + ex_b[31:0];
            cmd_sub: res_w = ex_a[31:0] - ex_b[31:0];
            cmd_sll: res_w = ex_a[31:0] << shamt_w;
            cmd_srl: res_w = ex_a[31:0] >> shamt_w;
            cmd_sra: res_w = a_lo_s >>> shamt_w;
            default: res_w = '0;
        endcase
    end

    // pick the view
    // W results are sign-extended from bit 31 into the upper word
    always_comb begin
        if (ex_word && ex_cmd != cmd_illegal) begin
            res_u.w.lo = res_w;
            res_u.w.hi = {32{res_w[31]}};
        end else begin
            res_u.d = res_d;
        end
    end

    // output register, one cycle after ex_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= ex_valid;
            // hold last result between operations
            if (ex_valid) begin
                result <= res_u.d;
            end
        end
    end

endmodule

//--- rtl/alu_operand_pipe.sv
module alu_operand_pipe #(
    parameter int STAGES = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  alu_pkg::alu_cmd_e dec_cmd,
    input  logic              dec_word,
    input  alu_pkg::word_t    dec_a,
    input  alu_pkg::word_t    dec_b,
    output logic              ex_valid,
    output alu_pkg::alu_cmd_e ex_cmd,
    output logic              ex_word,
    output alu_pkg::word_t    ex_a,
    output alu_pkg::word_t    ex_b
);
    import alu_pkg::*;

    // one entry per stage, index 0 is nearest to decode
    logic [STAGES-1:0] valid_q;
    alu_cmd_e          cmd_q  [STAGES];
    logic              word_q [STAGES];
    word_t             a_q    [STAGES];
    word_t             b_q    [STAGES];

    // valid shift chain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= dec_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // each stage loads when the entry behind it is valid
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            cmd_q[0]  <= dec_cmd;
            word_q[0] <= dec_word;
            a_q[0]    <= dec_a;
            b_q[0]    <= dec_b;
        end
        for (int i = 1; i < STAGES; i++) begin
            if (valid_q[i-1]) begin
                cmd_q[i]  <= cmd_q[i-1];
                word_q[i] <= word_q[i-1];
                a_q[i]    <= a_q[i-1];
                b_q[i]    <= b_q[i-1];
            end
        end
    end

    // last stage feeds execute
    assign ex_valid = valid_q[STAGES-1];
    assign ex_cmd   = cmd_q[STAGES-1];
    assign ex_word  = word_q[STAGES-1];
    assign ex_a     = a_q[STAGES-1];
    assign ex_b     = b_q[STAGES-1];

endmodule

//--- rtl/alu_pipe_top.sv
module alu_pipe_top #(
    parameter int STAGES = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  alu_pkg::opcode_t op,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    output logic             out_valid,
    output alu_pkg::word_t   result
);
    import alu_pkg::*;

    // decode outputs
    logic     dec_valid;
    alu_cmd_e dec_cmd;
    logic     dec_word;
    word_t    dec_a;
    word_t    dec_b;

    // delayed copies at the execute input
    logic     ex_valid;
    alu_cmd_e ex_cmd;
    logic     ex_word;
    word_t    ex_a;
    word_t    ex_b;

    // first stage, encoding check and operand capture
    alu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .funct3    (funct3),
        .funct7    (funct7),
        .a         (a),
        .b         (b),
        .dec_valid (dec_valid),
        .dec_cmd   (dec_cmd),
        .dec_word  (dec_word),
        .dec_a     (dec_a),
        .dec_b     (dec_b)
    );

    // STAGES cycles of delay ahead of execute
    alu_operand_pipe #(
        .STAGES (STAGES)
    ) u_operand_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_cmd   (dec_cmd),
        .dec_word  (dec_word),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .ex_valid  (ex_valid),
        .ex_cmd    (ex_cmd),
        .ex_word   (ex_word),
        .ex_a      (ex_a),
        .ex_b      (ex_b)
    );

    // compute and register the result
    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_cmd    (ex_cmd),
        .ex_word   (ex_word),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- rtl/alu_pkg.sv
package alu_pkg;

    // datapath width for RV64I
    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;

    // major opcode field, instruction bits [6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_op_imm = 7'b0010011;
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_imm_32 = 7'b0011011;
    localparam opcode_t op_op_32  = 7'b0111011;

    // funct3 codes of the integer ops
    // slt/sltu (010/011) are not supported
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srx     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // decoded command handed from decode to execute
    typedef enum logic [3:0] {
        cmd_add,
        cmd_sub,
        cmd_sll,
        cmd_srl,
        cmd_sra,
        cmd_xor,
        cmd_or,
        cmd_and,
        cmd_pass_b,
        cmd_illegal
    } alu_cmd_e;

    // result seen either as one doubleword or as two words
    typedef union packed {
        word_t d;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } w;
    } alu_word_u;

    // marker value for any rejected encoding
    localparam word_t illegal_result = 64'd12345;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the pipelined ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_alu \
    -f project.f -o tb_alu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
